/* design/cache_link_pkg.sv */
`default_nettype none

package cache_link_pkg;

  // network and cache geometry
  localparam int link_addr_width = 12;
  localparam int data_width = 32;
  localparam int mask_width = data_width / 8;
  localparam int byte_offset_width = $clog2(mask_width);
  localparam int coord_width = 4;
  localparam int reg_id_width = 5;
  localparam int sets = 8;
  localparam int ways = 2;
  localparam int block_words = 4;
  localparam int tag_entries = sets * ways;
  localparam int tag_index_width = $clog2(tag_entries);
  // one extra bit so the counters can hold tag_entries itself
  localparam int tag_count_width = tag_index_width + 1;
  localparam int block_offset_width = $clog2(block_words) + byte_offset_width;
  localparam int cache_addr_width = link_addr_width - 1 + byte_offset_width;

  typedef logic [link_addr_width-1:0] link_addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [mask_width-1:0] mask_t;
  typedef logic [coord_width-1:0] coord_t;
  typedef logic [reg_id_width-1:0] reg_id_t;
  typedef logic [cache_addr_width-1:0] cache_addr_t;

  typedef enum logic [2:0] {
    NET_STORE,
    NET_STORE_WORD,
    NET_LOAD,
    NET_CACHE_OP,
    NET_AMOSWAP,
    NET_AMOOR,
    NET_AMOADD
  } net_op_e;

  typedef enum logic [1:0] {
    OP_AFL,
    OP_AFLINV,
    OP_AINV
  } cache_op_e;

  typedef enum logic [4:0] {
    LB, LBU, LH, LHU, LW, SM,
    TAGST, TAGLA, TAGFL,
    AFL, AFLINV, AINV,
    AMOSWAP_W, AMOOR_W, AMOADD_W
  } cache_opcode_e;

  typedef enum logic [1:0] {
    RET_CREDIT,
    RET_INT_WB,
    RET_FLOAT_WB,
    RET_IFETCH
  } return_type_e;

  typedef enum logic [1:0] {
    REGION_DATA,
    REGION_TAG,
    REGION_ROUTE
  } region_e;

  typedef enum logic [1:0] {
    RESET,
    CLEAR_TAG,
    SERVE
  } ctrl_state_e;

  typedef struct packed {
    logic float_wb;
    logic icache_fetch;
    logic is_byte;
    logic is_hex;
    logic is_unsigned;
    logic [1:0] part_sel;
  } load_info_t;

  // reg_id carries a store mask, a cache op or a register id depending on op
  typedef struct packed {
    net_op_e op;
    link_addr_t addr;
    data_t payload;
    reg_id_t reg_id;
    load_info_t load_info;
    coord_t src_y;
    coord_t src_x;
  } req_packet_t;

  typedef struct packed {
    cache_opcode_e opcode;
    cache_addr_t addr;
    data_t data;
    mask_t mask;
  } cache_pkt_t;

  typedef struct packed {
    return_type_e ret_type;
    reg_id_t reg_id;
    coord_t y_coord;
    coord_t x_coord;
  } return_info_t;

  typedef struct packed {
    return_type_e ret_type;
    data_t data;
    reg_id_t reg_id;
    coord_t y_coord;
    coord_t x_coord;
  } return_packet_t;

endpackage

`default_nettype wire

/* design/request_fifo.sv */
`default_nettype none

module request_fifo #(
  parameter int fifo_els_p = 4
) (
  input  wire logic                      clk_i,
  input  wire logic                      reset_i,
  input  wire logic                      v_i,
  input  wire cache_link_pkg::req_packet_t packet_i,
  output logic                           ready_o,
  output logic                           v_o,
  output cache_link_pkg::req_packet_t    packet_o,
  input  wire logic                      yumi_i
);
  import cache_link_pkg::*;

  localparam int ptr_width_lp = (fifo_els_p > 1) ? $clog2(fifo_els_p) : 1;
  localparam int count_width_lp = $clog2(fifo_els_p + 1);

  req_packet_t mem_r [fifo_els_p];
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic push;
  logic pop;

  // a full buffer still takes a packet when the head leaves in the same cycle
  assign ready_o = (count_r != count_width_lp'(fifo_els_p)) | yumi_i;
  assign v_o = (count_r != '0);
  assign packet_o = mem_r[rd_ptr_r];

  assign push = v_i & ready_o;
  assign pop = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= packet_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r <= '0;
    end else begin
      // pointers wrap at the last slot
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(fifo_els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(fifo_els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_r + count_width_lp'(push) - count_width_lp'(pop);
    end
  end

endmodule

`default_nettype wire

/* design/op_translator.sv */
`default_nettype none

module op_translator (
  input  wire cache_link_pkg::req_packet_t packet_i,
  output cache_link_pkg::cache_pkt_t       cache_pkt_o,
  output cache_link_pkg::return_info_t     info_o,
  output cache_link_pkg::region_e          region_o
);
  import cache_link_pkg::*;

  load_info_t load_info;
  mask_t store_mask;
  cache_op_e cache_op;
  reg_id_t payload_reg_id;

  assign load_info = packet_i.load_info;
  assign store_mask = packet_i.reg_id[mask_width-1:0];
  assign cache_op = cache_op_e'(packet_i.reg_id[1:0]);

  // top address bits pick route register, tag memory or data memory
  always_comb begin
    if (packet_i.addr[link_addr_width-1 -: 2] == 2'b11) begin
      region_o = REGION_ROUTE;
    end else if (packet_i.addr[link_addr_width-1]) begin
      region_o = REGION_TAG;
    end else begin
      region_o = REGION_DATA;
    end
  end

  always_comb begin
    cache_pkt_o.opcode = TAGLA;
    if (region_o == REGION_TAG) begin
      case (packet_i.op)
        NET_STORE:    cache_pkt_o.opcode = TAGST;
        NET_LOAD:     cache_pkt_o.opcode = TAGLA;
        NET_CACHE_OP: cache_pkt_o.opcode = TAGFL;
        default:      cache_pkt_o.opcode = TAGLA;
      endcase
    end else if (region_o == REGION_DATA) begin
      case (packet_i.op)
        NET_STORE, NET_STORE_WORD: cache_pkt_o.opcode = SM;
        NET_AMOSWAP: cache_pkt_o.opcode = AMOSWAP_W;
        NET_AMOOR:   cache_pkt_o.opcode = AMOOR_W;
        NET_AMOADD:  cache_pkt_o.opcode = AMOADD_W;
        NET_CACHE_OP: begin
          case (cache_op)
            OP_AFLINV: cache_pkt_o.opcode = AFLINV;
            OP_AINV:   cache_pkt_o.opcode = AINV;
            default:   cache_pkt_o.opcode = AFL;
          endcase
        end
        NET_LOAD: begin
          if (load_info.is_byte) begin
            cache_pkt_o.opcode = load_info.is_unsigned ? LBU : LB;
          end else if (load_info.is_hex) begin
            cache_pkt_o.opcode = load_info.is_unsigned ? LHU : LH;
          end else begin
            cache_pkt_o.opcode = LW;
          end
        end
        default: cache_pkt_o.opcode = AFL;
      endcase
    end
  end

  assign cache_pkt_o.data = packet_i.payload;
  assign cache_pkt_o.mask = (packet_i.op == NET_STORE_WORD) ? '1 : store_mask;
  // word address then byte offset; only loads use part_sel
  assign cache_pkt_o.addr = {
    packet_i.addr[link_addr_width-2:0],
    (packet_i.op == NET_LOAD) ? load_info.part_sel : 2'b00
  };

  // register id sits in the lowest byte the mask enables
  always_comb begin
    payload_reg_id = packet_i.payload[reg_id_width-1:0];
    for (int i = mask_width - 1; i >= 0; i--) begin
      if (store_mask[i]) begin
        payload_reg_id = packet_i.payload[8*i +: reg_id_width];
      end
    end
  end

  always_comb begin
    case (packet_i.op)
      NET_LOAD: begin
        if (load_info.icache_fetch) begin
          info_o.ret_type = RET_IFETCH;
        end else if (load_info.float_wb) begin
          info_o.ret_type = RET_FLOAT_WB;
        end else begin
          info_o.ret_type = RET_INT_WB;
        end
      end
      NET_AMOSWAP, NET_AMOOR, NET_AMOADD: info_o.ret_type = RET_INT_WB;
      default: info_o.ret_type = RET_CREDIT;
    endcase
  end

  assign info_o.reg_id = ((packet_i.op == NET_STORE) | (packet_i.op == NET_CACHE_OP))
    ? payload_reg_id
    : packet_i.reg_id;
  assign info_o.y_coord = packet_i.src_y;
  assign info_o.x_coord = packet_i.src_x;

endmodule

`default_nettype wire

/* design/return_tracker.sv */
`default_nettype none

module return_tracker (
  input  wire logic                       clk_i,
  input  wire logic                       capture_i,
  input  wire cache_link_pkg::return_info_t info_i,
  input  wire logic                       advance_i,
  input  wire cache_link_pkg::data_t      data_i,
  output cache_link_pkg::return_packet_t  ret_packet_o
);
  import cache_link_pkg::*;

  // sender info for the request in tag lookup and in tag verify
  return_info_t lookup_r;
  return_info_t verify_r;

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      lookup_r <= info_i;
    end
  end

  // moves along with the cache pipeline
  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      verify_r <= lookup_r;
    end
  end

  always_comb begin
    ret_packet_o.ret_type = verify_r.ret_type;
    ret_packet_o.data = data_i;
    ret_packet_o.reg_id = verify_r.reg_id;
    ret_packet_o.y_coord = verify_r.y_coord;
    ret_packet_o.x_coord = verify_r.x_coord;
  end

endmodule

`default_nettype wire

/* design/link_ctrl.sv */
`default_nettype none

module link_ctrl (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,
  input  wire logic                     head_v_i,
  output logic                          head_yumi_o,
  input  wire cache_link_pkg::cache_pkt_t xlate_pkt_i,
  input  wire cache_link_pkg::region_e  region_i,
  input  wire logic                     payload_lsb_i,
  output cache_link_pkg::cache_pkt_t    cache_pkt_o,
  output logic                          cache_v_o,
  input  wire logic                     cache_ready_i,
  input  wire logic                     cache_v_i,
  output logic                          cache_yumi_o,
  output logic                          ret_v_o,
  input  wire logic                     ret_ready_i,
  output logic                          capture_o,
  output logic                          route_east_o
);
  import cache_link_pkg::*;

  localparam int pad_width_lp = cache_addr_width - tag_index_width - block_offset_width;

  ctrl_state_e state_r, state_n;
  logic [tag_count_width-1:0] sent_r, sent_n;
  logic [tag_count_width-1:0] received_r, received_n;
  logic route_east_r, route_east_n;
  logic all_sent;
  logic all_received;

  assign all_sent = (sent_r == tag_count_width'(tag_entries));
  assign all_received = (received_r == tag_count_width'(tag_entries));
  assign route_east_o = route_east_r;

  always_comb begin
    state_n = state_r;
    sent_n = sent_r;
    received_n = received_r;
    route_east_n = route_east_r;
    cache_pkt_o = xlate_pkt_i;
    cache_v_o = 1'b0;
    cache_yumi_o = 1'b0;
    ret_v_o = 1'b0;
    head_yumi_o = 1'b0;
    capture_o = 1'b0;
    case (state_r)
      RESET: begin
        state_n = CLEAR_TAG;
      end
      CLEAR_TAG: begin
        // one TAGST per tag entry with the index in the set and way bits
        cache_pkt_o.opcode = TAGST;
        cache_pkt_o.data = '0;
        cache_pkt_o.mask = '0;
        cache_pkt_o.addr = {
          {pad_width_lp{1'b0}},
          sent_r[tag_index_width-1:0],
          {block_offset_width{1'b0}}
        };
        cache_v_o = ~all_sent;
        // tag clear responses never go back to the network
        cache_yumi_o = cache_v_i;
        if (cache_v_o & cache_ready_i) begin
          sent_n = sent_r + 1'b1;
        end
        if (cache_v_i) begin
          received_n = received_r + 1'b1;
        end
        if (all_sent & all_received) begin
          state_n = SERVE;
        end
      end
      SERVE: begin
        cache_v_o = head_v_i;
        head_yumi_o = head_v_i & cache_ready_i;
        capture_o = head_v_i & cache_ready_i;
        ret_v_o = cache_v_i;
        cache_yumi_o = cache_v_i & ret_ready_i;
        // route register follows the no-op once the cache takes it
        if ((region_i == REGION_ROUTE) & head_v_i & cache_ready_i) begin
          route_east_n = payload_lsb_i;
        end
      end
      default: begin
        state_n = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RESET;
      sent_r <= '0;
      received_r <= '0;
      route_east_r <= 1'b0;
    end else begin
      state_r <= state_n;
      sent_r <= sent_n;
      received_r <= received_n;
      route_east_r <= route_east_n;
    end
  end

endmodule

`default_nettype wire

/* design/cache_link_top.sv */
`default_nettype none

module cache_link_top #(
  parameter int fifo_els_p = 4
) (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  input  wire logic                        req_v_i,
  input  wire cache_link_pkg::req_packet_t req_packet_i,
  output logic                             req_ready_o,
  output logic                             ret_v_o,
  output cache_link_pkg::return_packet_t   ret_packet_o,
  input  wire logic                        ret_ready_i,
  output cache_link_pkg::cache_pkt_t       cache_pkt_o,
  output logic                             cache_v_o,
  input  wire logic                        cache_ready_i,
  input  wire logic                        cache_v_i,
  input  wire cache_link_pkg::data_t       cache_data_i,
  output logic                             cache_yumi_o,
  input  wire logic                        cache_v_we_i,
  output logic                             route_east_o
);
  import cache_link_pkg::*;

  logic head_v;
  logic head_yumi;
  req_packet_t head_pkt;
  cache_pkt_t xlate_pkt;
  return_info_t xlate_info;
  region_e region;
  logic capture;

  request_fifo #(
    .fifo_els_p(fifo_els_p)
  ) fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(req_v_i),
    .packet_i(req_packet_i),
    .ready_o(req_ready_o),
    .v_o(head_v),
    .packet_o(head_pkt),
    .yumi_i(head_yumi)
  );

  op_translator xlate (
    .packet_i(head_pkt),
    .cache_pkt_o(xlate_pkt),
    .info_o(xlate_info),
    .region_o(region)
  );

  return_tracker tracker (
    .clk_i(clk_i),
    .capture_i(capture),
    .info_i(xlate_info),
    .advance_i(cache_v_we_i),
    .data_i(cache_data_i),
    .ret_packet_o(ret_packet_o)
  );

  link_ctrl ctrl (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .head_v_i(head_v),
    .head_yumi_o(head_yumi),
    .xlate_pkt_i(xlate_pkt),
    .region_i(region),
    .payload_lsb_i(head_pkt.payload[0]),
    .cache_pkt_o(cache_pkt_o),
    .cache_v_o(cache_v_o),
    .cache_ready_i(cache_ready_i),
    .cache_v_i(cache_v_i),
    .cache_yumi_o(cache_yumi_o),
    .ret_v_o(ret_v_o),
    .ret_ready_i(ret_ready_i),
    .capture_o(capture),
    .route_east_o(route_east_o)
  );

endmodule

`default_nettype wire

/* tests/cache_link_assertions.sv */
`default_nettype none

module cache_link_assertions (
  input wire logic clk_i,
  input wire logic reset_i,
  input wire logic cache_req_v_i,
  input wire logic cache_req_ready_i,
  input wire logic cache_resp_v_i,
  input wire logic cache_yumi_i,
  input wire logic ret_v_i,
  input wire logic req_ready_i,
  input wire logic route_east_i
);

  // an offered cache packet stays until taken
  hold_cache_v: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_i && !cache_req_ready_i |=> cache_req_v_i)
    else $error("cache_v_o dropped before the cache took the packet");

  reset_outputs: assert property (@(posedge clk_i)
    reset_i |=> !cache_req_v_i && !cache_yumi_i && !ret_v_i && !route_east_i && req_ready_i)
    else $error("control outputs not idle after reset");

  yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_yumi_i |-> cache_resp_v_i)
    else $error("cache_yumi_o without cache_v_i");

  // tag clear responses are consumed at once and never returned
  ret_follows_v: assert property (@(posedge clk_i) disable iff (reset_i)
    (ret_v_i == cache_resp_v_i) || (cache_yumi_i && !ret_v_i))
    else $error("ret_v_o does not follow cache_v_i");

endmodule

bind cache_link_top cache_link_assertions checks (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .cache_req_v_i(cache_v_o),
  .cache_req_ready_i(cache_ready_i),
  .cache_resp_v_i(cache_v_i),
  .cache_yumi_i(cache_yumi_o),
  .ret_v_i(ret_v_o),
  .req_ready_i(req_ready_o),
  .route_east_i(route_east_o)
);

`default_nettype wire

/* tests/cache_link_tb.sv */
`default_nettype none

module cache_link_tb;
  import cache_link_pkg::*;

  localparam int num_reqs = 64;
  localparam int clk_period = 100;
  localparam int mem_words = 2 ** (cache_addr_width - 2);

  logic clk_i;
  logic reset_i;
  logic req_v_i;
  req_packet_t req_packet_i;
  logic req_ready_o;
  logic ret_v_o;
  return_packet_t ret_packet_o;
  logic ret_ready_i;
  cache_pkt_t cache_pkt_o;
  logic cache_v_o;
  logic cache_ready_i;
  logic cache_v_i;
  data_t cache_data_i;
  logic cache_yumi_o;
  logic cache_v_we_i;
  logic route_east_o;

  integer seed;
  req_packet_t stim [num_reqs];
  req_packet_t pending_q [$];
  return_packet_t exp_ret_q [$];
  data_t mem [mem_words];
  int next_req;
  int ret_count;
  int tags_sent;
  int tags_received;
  // cache model request in lookup and response on offer
  logic lk_valid;
  data_t lk_data;
  logic vf_valid;
  data_t vf_data;
  logic exp_route;
  req_packet_t head_req;
  return_packet_t exp_ret;

  cache_link_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error at time %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  function automatic req_packet_t random_request(int kind);
    req_packet_t r;
    logic [31:0] rnd;
    rnd = $random(seed);
    r.payload = $random(seed);
    // small data window so loads see earlier stores
    r.addr = link_addr_t'(rnd[3:0]);
    r.reg_id = rnd[8:4];
    r.load_info = rnd[15:9];
    r.src_y = rnd[19:16];
    r.src_x = rnd[23:20];
    case (kind)
      2: begin
        r.op = NET_STORE;
        if (r.reg_id[3:0] == 4'h0) begin
          r.reg_id[0] = 1'b1;
        end
      end
      3: r.op = NET_STORE_WORD;
      4: r.op = (rnd[25:24] == 2'd0) ? NET_AMOSWAP : (rnd[25:24] == 2'd1) ? NET_AMOOR : NET_AMOADD;
      5: begin
        r.op = NET_CACHE_OP;
        r.reg_id[1:0] = (rnd[25:24] == 2'd3) ? 2'd0 : rnd[25:24];
      end
      6: begin
        r.addr[11:10] = 2'b10;
        r.op = (rnd[25:24] == 2'd0) ? NET_STORE : (rnd[25:24] == 2'd1) ? NET_LOAD :
               (rnd[25:24] == 2'd2) ? NET_CACHE_OP : NET_AMOADD;
      end
      7: begin
        r.addr[11:10] = 2'b11;
        r.op = NET_STORE;
      end
      default: r.op = NET_LOAD;
    endcase
    return r;
  endfunction

  function automatic cache_pkt_t expected_cache_pkt(req_packet_t req);
    cache_pkt_t pkt;
    pkt.data = req.payload;
    pkt.mask = (req.op == NET_STORE_WORD) ? 4'hf : req.reg_id[3:0];
    pkt.addr = {req.addr[10:0], (req.op == NET_LOAD) ? req.load_info.part_sel : 2'b00};
    if (req.addr[11:10] == 2'b11) begin
      pkt.opcode = TAGLA;
    end else if (req.addr[11]) begin
      if (req.op == NET_STORE) pkt.opcode = TAGST;
      else if (req.op == NET_CACHE_OP) pkt.opcode = TAGFL;
      else pkt.opcode = TAGLA;
    end else if (req.op == NET_STORE || req.op == NET_STORE_WORD) begin
      pkt.opcode = SM;
    end else if (req.op == NET_AMOSWAP) begin
      pkt.opcode = AMOSWAP_W;
    end else if (req.op == NET_AMOOR) begin
      pkt.opcode = AMOOR_W;
    end else if (req.op == NET_AMOADD) begin
      pkt.opcode = AMOADD_W;
    end else if (req.op == NET_CACHE_OP) begin
      if (req.reg_id[1:0] == 2'd1) pkt.opcode = AFLINV;
      else if (req.reg_id[1:0] == 2'd2) pkt.opcode = AINV;
      else pkt.opcode = AFL;
    end else if (req.load_info.is_byte) begin
      pkt.opcode = req.load_info.is_unsigned ? LBU : LB;
    end else if (req.load_info.is_hex) begin
      pkt.opcode = req.load_info.is_unsigned ? LHU : LH;
    end else begin
      pkt.opcode = LW;
    end
    return pkt;
  endfunction

  function automatic return_packet_t expected_return(req_packet_t req, data_t data);
    return_packet_t ret;
    int lowest;
    ret.data = data;
    ret.y_coord = req.src_y;
    ret.x_coord = req.src_x;
    ret.reg_id = req.reg_id;
    if (req.op == NET_LOAD) begin
      ret.ret_type = req.load_info.icache_fetch ? RET_IFETCH :
                     req.load_info.float_wb ? RET_FLOAT_WB : RET_INT_WB;
    end else if (req.op == NET_AMOSWAP || req.op == NET_AMOOR || req.op == NET_AMOADD) begin
      ret.ret_type = RET_INT_WB;
    end else begin
      ret.ret_type = RET_CREDIT;
    end
    if (req.op == NET_STORE || req.op == NET_CACHE_OP) begin
      // empty mask falls back to byte 0
      lowest = 0;
      while (lowest < 3 && !req.reg_id[lowest]) lowest++;
      if (req.reg_id[3:0] == 4'h0) lowest = 0;
      ret.reg_id = req.payload[8*lowest +: 5];
    end
    return ret;
  endfunction

  // word memory of the cache model and the response word it gives
  function automatic data_t cache_access(cache_pkt_t pkt);
    int word;
    data_t old;
    data_t resp;
    word = int'(pkt.addr[cache_addr_width-1:2]);
    old = mem[word];
    resp = '0;
    case (pkt.opcode)
      LB, LBU, LH, LHU, LW: resp = old;
      SM: begin
        for (int b = 0; b < 4; b++) begin
          if (pkt.mask[b]) mem[word][8*b +: 8] = pkt.data[8*b +: 8];
        end
      end
      AMOSWAP_W: begin
        mem[word] = pkt.data;
        resp = old;
      end
      AMOOR_W: begin
        mem[word] = old | pkt.data;
        resp = old;
      end
      AMOADD_W: begin
        mem[word] = old + pkt.data;
        resp = old;
      end
      default: resp = '0;
    endcase
    return resp;
  endfunction

  task automatic drive_step();
    check_value("route_east_o", 32'(route_east_o), 32'(exp_route));
    cache_v_i = vf_valid;
    cache_data_i = vf_valid ? vf_data : '0;
    cache_v_we_i = lk_valid & ~vf_valid;
    // lookup slot must be free or moving on
    cache_ready_i = (($random(seed) & 3) != 0) & (~lk_valid | cache_v_we_i);
    ret_ready_i = ($random(seed) & 3) != 0;
    if (next_req < num_reqs) begin
      req_packet_i = stim[next_req];
      req_v_i = ($random(seed) & 7) != 0;
    end else begin
      req_v_i = 1'b0;
    end
  endtask

  // comparison and cache model update at the rising edge
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (cache_yumi_o) begin
        if (!vf_valid) fail_run("cache response consumed while none was offered");
        vf_valid = 1'b0;
        if (tags_received < tag_entries) tags_received++;
      end
      if (ret_v_o & ret_ready_i) begin
        if (exp_ret_q.size() == 0) fail_run("return packet sent with no request outstanding");
        exp_ret = exp_ret_q.pop_front();
        check_value("ret_packet_o.ret_type", 32'(ret_packet_o.ret_type), 32'(exp_ret.ret_type));
        check_value("ret_packet_o.reg_id", 32'(ret_packet_o.reg_id), 32'(exp_ret.reg_id));
        check_value("ret_packet_o.y_coord", 32'(ret_packet_o.y_coord), 32'(exp_ret.y_coord));
        check_value("ret_packet_o.x_coord", 32'(ret_packet_o.x_coord), 32'(exp_ret.x_coord));
        check_value("ret_packet_o.data", ret_packet_o.data, exp_ret.data);
        ret_count++;
      end
      if (cache_v_we_i) begin
        vf_valid = 1'b1;
        vf_data = lk_data;
        lk_valid = 1'b0;
      end
      if (cache_v_o & cache_ready_i) begin
        if (tags_sent < tag_entries) begin
          check_value("cache_pkt_o.opcode", 32'(cache_pkt_o.opcode), 32'(TAGST));
          check_value("cache_pkt_o.addr", 32'(cache_pkt_o.addr), 32'(tags_sent * block_words * 4));
          check_value("cache_pkt_o.data", cache_pkt_o.data, 32'h0);
          tags_sent++;
          lk_data = '0;
        end else begin
          if (tags_received != tag_entries) fail_run("request sent before tag clear finished");
          if (pending_q.size() == 0) fail_run("cache packet sent with no network request");
          head_req = pending_q.pop_front();
          check_value("cache_pkt_o.opcode", 32'(cache_pkt_o.opcode),
                      32'(expected_cache_pkt(head_req).opcode));
          check_value("cache_pkt_o.addr", 32'(cache_pkt_o.addr),
                      32'(expected_cache_pkt(head_req).addr));
          check_value("cache_pkt_o.data", cache_pkt_o.data, expected_cache_pkt(head_req).data);
          check_value("cache_pkt_o.mask", 32'(cache_pkt_o.mask),
                      32'(expected_cache_pkt(head_req).mask));
          lk_data = cache_access(cache_pkt_o);
          exp_ret_q.push_back(expected_return(head_req, lk_data));
          if (head_req.addr[11:10] == 2'b11) exp_route = head_req.payload[0];
        end
        lk_valid = 1'b1;
      end
      if (req_v_i & req_ready_o) begin
        pending_q.push_back(req_packet_i);
        next_req++;
      end
    end
  end

  initial begin
    seed = 44410;
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_packet_i = '0;
    ret_ready_i = 1'b0;
    cache_ready_i = 1'b0;
    cache_v_i = 1'b0;
    cache_data_i = '0;
    cache_v_we_i = 1'b0;
    next_req = 0;
    ret_count = 0;
    tags_sent = 0;
    tags_received = 0;
    lk_valid = 1'b0;
    lk_data = '0;
    vf_valid = 1'b0;
    vf_data = '0;
    exp_route = 1'b0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = {5'b0, i[10:0], 5'h15, ~i[10:0]};
    end
    for (int i = 0; i < num_reqs; i++) begin
      stim[i] = random_request($random(seed) & 7);
    end
    // route stores that toggle the routing bit
    stim[20] = random_request(7);
    stim[20].payload[0] = 1'b1;
    stim[30] = random_request(7);
    stim[30].payload[0] = 1'b0;
    stim[45] = random_request(7);
    stim[45].payload[0] = 1'b1;
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;
    drive_step();
    while (ret_count < num_reqs) begin
      @(negedge clk_i);
      drive_step();
    end
    repeat (5) begin
      @(negedge clk_i);
      drive_step();
    end
    if (pending_q.size() == 0 && exp_ret_q.size() == 0 && !lk_valid && !vf_valid) begin
      $display("All tests passed!");
      $finish;
    end else begin
      fail_run("requests were left unfinished at the end of the run");
    end
  end

  // time limit from the request count
  initial begin
    repeat (num_reqs * 40 + 200) @(posedge clk_i);
    fail_run("timeout: not every request returned in time");
  end

endmodule

`default_nettype wire

/* project.f */
design/cache_link_pkg.sv
design/request_fifo.sv
design/op_translator.sv
design/return_tracker.sv
design/link_ctrl.sv
design/cache_link_top.sv
tests/cache_link_assertions.sv
tests/cache_link_tb.sv

/* run.sh */
#!/bin/sh
# build and run the cache link testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module cache_link_tb \
  -o cache_link_sim && ./obj_dir/cache_link_sim > sim.log 2>&1 || echo "build or simulation error"
cat sim.log 2>/dev/null
grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation FAILED: no pass line in log"; exit 1; }
exit 0
